// File: cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// ==================================================
// address split  tag | index | offset
// ==================================================
`define CACHE_ADDR_W    32
`define CACHE_TAG_W     23
`define CACHE_INDEX_W   6
`define CACHE_OFFSET_W  3

// ==================================================
// storage geometry
// ==================================================
`define CACHE_LINE_W    64  // eight bytes per line
`define CACHE_BYTE_W    8
`define CACHE_SETS      64  // one set per index value

`endif

// File: cache_pkg.sv
`default_nettype none

`include "cache_macros.svh"

package cache_pkg;

  // ==================================================
  // address fields
  // ==================================================
  typedef logic [`CACHE_ADDR_W-1:0]   addr_t;
  typedef logic [`CACHE_TAG_W-1:0]    tag_t;    // address[31:9]
  typedef logic [`CACHE_INDEX_W-1:0]  index_t;  // address[8:3]
  typedef logic [`CACHE_OFFSET_W-1:0] offset_t; // address[2:0]

  // ==================================================
  // data and way selection
  // ==================================================
  typedef logic [`CACHE_LINE_W-1:0] line_t;
  typedef logic [`CACHE_BYTE_W-1:0] byte_t;

  typedef enum logic {
    way0,
    way1
  } way_t;

endpackage

`default_nettype wire

// File: ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

  // lookup sequence, one cycle per state
  typedef enum logic [1:0] {
    predict,    // compare the predicted way
    alternate,  // compare the other way
    fill,       // load data_line into the FIFO victim
    done        // write_ready strobe
  } lookup_state_t;

endpackage

`default_nettype wire

// File: way_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module way_store (
  input  wire                   clk,
  input  wire                   reset,
  input  wire cache_pkg::index_t index,
  input  wire                   fill_en,
  input  wire cache_pkg::tag_t  fill_tag,
  input  wire cache_pkg::line_t fill_data,
  output cache_pkg::line_t      rd_data,
  output cache_pkg::tag_t       rd_tag,
  output logic                  rd_valid
);

  import cache_pkg::*;

  // ==================================================
  // storage
  // ==================================================
  line_t                  data_mem [`CACHE_SETS];
  tag_t                   tag_mem  [`CACHE_SETS];
  logic [`CACHE_SETS-1:0] valid_q;

  // only a miss fill writes a way, hits leave the entry alone
  always_ff @(posedge clk) begin
    if (fill_en) begin
      data_mem[index] <= fill_data;
      tag_mem[index]  <= fill_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;  // cold cache
    end else if (fill_en) begin
      valid_q[index] <= 1'b1;
    end
  end

  // ==================================================
  // read port, same cycle as index
  // ==================================================
  assign rd_data  = data_mem[index];
  assign rd_tag   = tag_mem[index];
  assign rd_valid = valid_q[index];  // masks unwritten tags

endmodule

`default_nettype wire

// File: replace_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module replace_store (
  input  wire                   clk,
  input  wire                   reset,
  input  wire cache_pkg::index_t index,
  input  wire                   update,
  input  wire                   fill,
  input  wire cache_pkg::way_t  hit_way,
  output cache_pkg::way_t       pred_way,
  output cache_pkg::way_t       fifo_way
);

  import cache_pkg::*;

  // one bit per set, 0 means way0
  logic [`CACHE_SETS-1:0] pred_bits;
  logic [`CACHE_SETS-1:0] fifo_bits;

  // ==================================================
  // update at the end of each lookup
  // ==================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      pred_bits <= '0;
      fifo_bits <= '0;  // first fill goes to way0
    end else if (update) begin
      pred_bits[index] <= hit_way;
      if (fill) begin
        fifo_bits[index] <= ~fifo_bits[index];  // victim alternates
      end
    end
  end

  assign pred_way = way_t'(pred_bits[index]);
  assign fifo_way = way_t'(fifo_bits[index]);

endmodule

`default_nettype wire

// File: lookup_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module lookup_ctrl (
  input  wire                    clk,
  input  wire                    reset,
  input  wire cache_pkg::tag_t   tag,
  input  wire cache_pkg::offset_t offset,
  input  wire cache_pkg::line_t  data_line,
  input  wire cache_pkg::line_t  rd_data0,
  input  wire cache_pkg::line_t  rd_data1,
  input  wire cache_pkg::tag_t   rd_tag0,
  input  wire cache_pkg::tag_t   rd_tag1,
  input  wire                    rd_valid0,
  input  wire                    rd_valid1,
  input  wire cache_pkg::way_t   pred_way,
  input  wire cache_pkg::way_t   fifo_way,
  output logic [1:0]             fill_en,
  output cache_pkg::tag_t        fill_tag,
  output cache_pkg::line_t       fill_data,
  output logic                   update,
  output logic                   fill,
  output cache_pkg::way_t        hit_way,
  output logic                   write_ready,
  output cache_pkg::byte_t       data_out
);

  import cache_pkg::*;
  import ctrl_pkg::*;

  lookup_state_t state;
  line_t         line_q;   // line that serves the lookup
  way_t          way_q;    // way that served it
  logic          fill_q;   // lookup ended with a fill

  line_t      way_data [2];
  tag_t       way_tag  [2];
  logic [1:0] way_valid;
  way_t       alt_way;
  logic       pred_hit;
  logic       alt_hit;
  byte_t      byte_sel;

  // ==================================================
  // hit detection
  // ==================================================
  assign way_data[0] = rd_data0;
  assign way_data[1] = rd_data1;
  assign way_tag[0]  = rd_tag0;
  assign way_tag[1]  = rd_tag1;
  assign way_valid   = {rd_valid1, rd_valid0};

  assign alt_way = way_t'(~pred_way);

  // each way is judged by its own valid bit
  assign pred_hit = way_valid[pred_way] && (way_tag[pred_way] == tag);
  assign alt_hit  = way_valid[alt_way] && (way_tag[alt_way] == tag);

  // ==================================================
  // lookup FSM
  // ==================================================
  // the fill port hides the state literal, hence the scoped ctrl_pkg::fill
  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= predict;
      way_q  <= way0;
      fill_q <= 1'b0;
    end else begin
      case (state)
        predict: begin
          way_q  <= pred_way;
          fill_q <= 1'b0;
          if (pred_hit) begin
            state <= done;
          end else begin
            state <= alternate;
          end
        end
        alternate: begin
          way_q <= alt_way;
          if (alt_hit) begin
            state <= done;
          end else begin
            state <= ctrl_pkg::fill;
          end
        end
        ctrl_pkg::fill: begin
          way_q  <= fifo_way;  // prediction follows the new line
          fill_q <= 1'b1;
          state  <= done;
        end
        default: begin
          state <= predict;  // done lasts one cycle
        end
      endcase
    end
  end

  // serving line, captured from whichever source the state looks at
  always_ff @(posedge clk) begin
    case (state)
      predict:        line_q <= way_data[pred_way];
      alternate:      line_q <= way_data[alt_way];
      ctrl_pkg::fill: line_q <= data_line;  // byte comes from the new line
      default:        line_q <= line_q;
    endcase
  end

  // ==================================================
  // fill port toward the ways
  // ==================================================
  always_comb begin
    fill_en = 2'b00;
    if (state == ctrl_pkg::fill) begin
      fill_en[fifo_way] = 1'b1;  // way writes at the edge leaving fill
    end
  end

  assign fill_tag  = tag;
  assign fill_data = data_line;

  // ==================================================
  // strobe, replacement update and byte select
  // ==================================================
  assign write_ready = (state == done);
  assign update      = (state == done);
  assign fill        = fill_q;
  assign hit_way     = way_q;

  // offset * 8 as a bit position
  assign byte_sel = line_q[{offset, 3'b000} +: `CACHE_BYTE_W];
  assign data_out = write_ready ? byte_sel : '0;

endmodule

`default_nettype wire

// File: cache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_top (
  input  wire                   clk,
  input  wire                   reset,
  input  wire cache_pkg::addr_t address,
  input  wire cache_pkg::line_t data_line,
  output cache_pkg::byte_t      data_out,
  output logic                  write_ready
);

  import cache_pkg::*;

  // ==================================================
  // address fields
  // ==================================================
  tag_t    tag;
  index_t  index;
  offset_t offset;

  assign tag    = address[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
  assign index  = address[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
  assign offset = address[`CACHE_OFFSET_W-1:0];

  line_t      rd_data0;
  line_t      rd_data1;
  tag_t       rd_tag0;
  tag_t       rd_tag1;
  logic       rd_valid0;
  logic       rd_valid1;
  way_t       pred_way;
  way_t       fifo_way;
  logic [1:0] fill_en;   // one bit per way
  tag_t       fill_tag;
  line_t      fill_data;
  logic       update;
  logic       fill;
  way_t       hit_way;

  // ==================================================
  // storage
  // ==================================================
  way_store way0_store (
    .clk       (clk),
    .reset     (reset),
    .index     (index),
    .fill_en   (fill_en[0]),
    .fill_tag  (fill_tag),
    .fill_data (fill_data),
    .rd_data   (rd_data0),
    .rd_tag    (rd_tag0),
    .rd_valid  (rd_valid0)
  );

  way_store way1_store (
    .clk       (clk),
    .reset     (reset),
    .index     (index),
    .fill_en   (fill_en[1]),
    .fill_tag  (fill_tag),
    .fill_data (fill_data),
    .rd_data   (rd_data1),
    .rd_tag    (rd_tag1),
    .rd_valid  (rd_valid1)
  );

  replace_store u_replace (
    .clk      (clk),
    .reset    (reset),
    .index    (index),
    .update   (update),
    .fill     (fill),
    .hit_way  (hit_way),
    .pred_way (pred_way),
    .fifo_way (fifo_way)
  );

  // ==================================================
  // controller
  // ==================================================
  lookup_ctrl u_ctrl (
    .clk         (clk),
    .reset       (reset),
    .tag         (tag),
    .offset      (offset),
    .data_line   (data_line),
    .rd_data0    (rd_data0),
    .rd_data1    (rd_data1),
    .rd_tag0     (rd_tag0),
    .rd_tag1     (rd_tag1),
    .rd_valid0   (rd_valid0),
    .rd_valid1   (rd_valid1),
    .pred_way    (pred_way),
    .fifo_way    (fifo_way),
    .fill_en     (fill_en),
    .fill_tag    (fill_tag),
    .fill_data   (fill_data),
    .update      (update),
    .fill        (fill),
    .hit_way     (hit_way),
    .write_ready (write_ready),
    .data_out    (data_out)
  );

endmodule

`default_nettype wire

// File: cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_tb;

  import cache_pkg::*;

  localparam int timeout_cycles = 16;
  localparam int random_lookups = 64;

  localparam tag_t   tag_a = 23'h1a2b3c;
  localparam tag_t   tag_b = 23'h0f0f0f;
  localparam tag_t   tag_c = 23'h7ffe01;
  localparam index_t set_a = 6'd5;

  logic  clk;
  logic  reset;
  addr_t address;
  line_t data_line;
  byte_t data_out;
  logic  write_ready;

  integer seed;
  int     error_count;
  int     check_count;
  int     test_count;
  int     errors_at_test_start;

  // ==================================================
  // reference model state
  // ==================================================
  tag_t model_tag   [`CACHE_SETS][2];
  logic model_valid [`CACHE_SETS][2];
  logic model_pred  [`CACHE_SETS];
  logic model_fifo  [`CACHE_SETS];

  tag_t   tag_pool [4];
  index_t set_pool [3];

  cache_top UUT (
    .clk         (clk),
    .reset       (reset),
    .address     (address),
    .data_line   (data_line),
    .data_out    (data_out),
    .write_ready (write_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // line the memory side returns for a tag and set
  function automatic line_t make_line(input tag_t tag, input index_t index);
    logic [31:0] hi;
    logic [31:0] lo;
    hi = {tag, index, 3'b101};
    lo = (hi * 32'h9e37_79b1) ^ {index, 26'h155_5555};
    return {hi, lo};
  endfunction

  function automatic addr_t make_addr(input tag_t tag, input index_t index,
                                      input offset_t offset);
    return {tag, index, offset};
  endfunction

  function automatic byte_t line_byte(input line_t line, input offset_t offset);
    line_t shifted;
    shifted = line >> (8 * offset);  // byte 0 sits in the low bits
    return shifted[7:0];
  endfunction

  task automatic clear_model();
    for (int s = 0; s < `CACHE_SETS; s++) begin
      model_valid[s][0] = 1'b0;
      model_valid[s][1] = 1'b0;
      model_tag[s][0]   = '0;
      model_tag[s][1]   = '0;
      model_pred[s]     = 1'b0;
      model_fifo[s]     = 1'b0;
    end
  endtask

  // predicted way, then the other one, then fill the FIFO victim
  task automatic model_lookup(input addr_t addr, output int gap);
    tag_t   tag;
    index_t index;
    logic   pred;
    logic   way;
    tag   = addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    index = addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
    pred  = model_pred[index];
    if (model_valid[index][pred] && model_tag[index][pred] == tag) begin
      gap = 2;
      way = pred;
    end else if (model_valid[index][!pred] && model_tag[index][!pred] == tag) begin
      gap = 3;
      way = !pred;
    end else begin
      gap = 4;
      way = model_fifo[index];
      model_tag[index][way]   = tag;
      model_valid[index][way] = 1'b1;
      model_fifo[index]       = !model_fifo[index];
    end
    model_pred[index] = way;  // prediction follows the serving way
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    check_count++;
    assert (actual === expected)
    else begin
      $display("mismatch at %0t: %s expected %0h, got %0h",
               $time, name, expected, actual);
      error_count++;
    end
  endtask

  // ==================================================
  // one lookup, entered and left at a falling edge
  // ==================================================
  task automatic run_lookup(input addr_t addr, input int expected_gap,
                            input bit after_reset);
    int    model_gap;
    int    cycles;
    bit    seen;
    byte_t expected_byte;
    cycles = 1;  // release cycle stands in for the cycle after a pulse
    if (!after_reset) begin
      // the pulse cycle still belongs to the previous address
      @(negedge clk);
      check_value("write_ready", 64'(write_ready), 64'(0));
      check_value("data_out", 64'(data_out), 64'(0));
    end
    address   = addr;
    data_line = make_line(addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W],
                          addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W]);
    expected_byte = line_byte(data_line, addr[`CACHE_OFFSET_W-1:0]);
    model_lookup(addr, model_gap);
    if (expected_gap != 0) begin
      check_count++;
      assert (model_gap == expected_gap)
      else begin
        $display("scenario error at %0t: model gives gap %0d where the test expects %0d",
                 $time, model_gap, expected_gap);
        error_count++;
      end
    end
    seen = 1'b0;
    while (!seen && cycles < timeout_cycles) begin
      @(negedge clk);
      cycles++;
      if (write_ready) begin
        seen = 1'b1;
      end else begin
        check_value("data_out", 64'(data_out), 64'(0));  // zero outside done
      end
    end
    if (!seen) begin
      $display("timeout: no write_ready pulse within %0d cycles for address %h",
               timeout_cycles, addr);
      error_count++;
    end else begin
      check_value("data_out", 64'(data_out), 64'(expected_byte));
      check_value("write_ready gap", 64'(cycles), 64'(model_gap));
    end
  endtask

  task automatic finish_test(input string name);
    test_count++;
    if (error_count == errors_at_test_start) begin
      $display("test %0d %s: ok", test_count, name);
    end else begin
      $display("test %0d %s: %0d errors", test_count, name,
               error_count - errors_at_test_start);
    end
    errors_at_test_start = error_count;
  endtask

  // ==================================================
  // test sequence
  // ==================================================
  initial begin
    logic [31:0] r;
    seed                 = 32'hc374;
    error_count          = 0;
    check_count          = 0;
    test_count           = 0;
    errors_at_test_start = 0;
    reset                = 1'b1;
    address              = '0;
    data_line            = '0;
    tag_pool[0] = tag_a;
    tag_pool[1] = tag_b;
    tag_pool[2] = tag_c;
    tag_pool[3] = 23'h000123;
    set_pool[0] = set_a;
    set_pool[1] = 6'd17;
    set_pool[2] = 6'd42;
    clear_model();

    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      check_value("write_ready", 64'(write_ready), 64'(0));
    end
    reset = 1'b0;
    run_lookup(make_addr(tag_a, set_a, 3'd3), 4, 1'b1);  // cold cache
    finish_test("cold miss after reset");

    run_lookup(make_addr(tag_a, set_a, 3'd3), 2, 1'b0);
    for (int i = 0; i < 8; i++) begin
      run_lookup(make_addr(tag_a, set_a, offset_t'(i)), 2, 1'b0);
    end
    finish_test("predicted hit and byte select");

    run_lookup(make_addr(tag_b, set_a, 3'd1), 4, 1'b0);  // goes to way1
    run_lookup(make_addr(tag_a, set_a, 3'd6), 3, 1'b0);
    run_lookup(make_addr(tag_a, set_a, 3'd2), 2, 1'b0);
    finish_test("alternate hit and prediction update");

    run_lookup(make_addr(tag_c, set_a, 3'd0), 4, 1'b0);  // evicts tag_a
    run_lookup(make_addr(tag_b, set_a, 3'd7), 3, 1'b0);
    run_lookup(make_addr(tag_a, set_a, 3'd4), 4, 1'b0);
    run_lookup(make_addr(tag_c, set_a, 3'd5), 3, 1'b0);
    finish_test("fifo eviction");

    for (int i = 0; i < random_lookups; i++) begin
      r = $random(seed);
      run_lookup(make_addr(tag_pool[r[3:2]], set_pool[r[5:4] % 3], r[8:6]), 0, 1'b0);
    end
    finish_test("random lookups against model");

    $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+.
cache_pkg.sv
ctrl_pkg.sv
way_store.sv
replace_store.sv
lookup_ctrl.sv
cache_top.sv
cache_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module cache_tb -o cache_sim
./obj_dir/cache_sim | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
